//--- compile.f
+incdir+common
common/md_types_pkg.sv
common/md_fsm_pkg.sv
mult/md_mult.sv
div/md_div.sv
design/md_ctrl.sv
design/md_top.sv
dv/md_sva.sv
dv/md_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the multiply/divide testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module md_tb -f compile.f -o md_sim \
  || { echo "Build failed"; exit 1; }
./obj_dir/md_sim 2>&1 | tee sim.log \
  || { echo "Simulation ended with an error"; exit 1; }
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- dv/md_tb.sv
// Directed testbench of the multiply/divide unit
// Runs MUL, MULH, DIV and REM against a 64-bit reference model

module md_tb
  import md_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // Operations issued by all tests together
  localparam int NUM_OPS     = 72;
  localparam int CYCLE_LIMIT = 80 * NUM_OPS;

  logic         clk_i;
  logic         rst_ni;
  logic         start_i;
  md_op_e       op_i;
  word_t        op_a_i;
  word_t        op_b_i;
  signed_mode_t signed_mode_i;
  logic         ready_o;
  logic         valid_o;
  word_t        result_o;
  logic         result_ready_i;

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  md_top u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .op_i           (op_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .signed_mode_i  (signed_mode_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .result_o       (result_o),
    .result_ready_i (result_ready_i)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the DUT did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  // Expected result from 64-bit arithmetic and the RISC-V division by zero rule
  function automatic word_t ref_result(input md_op_e op, input word_t a, input word_t b,
                                       input signed_mode_t mode);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    longint      q;
    longint      r;
    ea   = mode[0] ? {{32{a[31]}}, a} : {32'h0, a};
    eb   = mode[1] ? {{32{b[31]}}, b} : {32'h0, b};
    prod = ea * eb;
    q    = 0;
    r    = 0;
    if (b != '0) begin
      q = $signed(ea) / $signed(eb);
      r = $signed(ea) % $signed(eb);
    end
    case (op)
      MD_OP_MUL:  return prod[31:0];
      MD_OP_MULH: return prod[63:32];
      MD_OP_DIV:  return (b == '0) ? '1 : q[31:0];
      default:    return (b == '0) ? a : r[31:0];
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("** Error [%s]: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  // Hold start until the DUT accepts, then drop it on the accept edge
  task automatic send_op(input md_op_e op, input word_t a, input word_t b,
                         input signed_mode_t mode);
    @(posedge clk_i);
    start_i       <= 1'b1;
    op_i          <= op;
    op_a_i        <= a;
    op_b_i        <= b;
    signed_mode_i <= mode;
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  // Cycles counted from the accept edge to the edge that raises valid_o
  task automatic wait_result(output word_t res, output int lat);
    lat = 0;
    @(negedge clk_i);
    while (!valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    res = result_o;
  endtask

  // A latency of 0 leaves the cycle count unchecked
  task automatic run_op(input string name, input md_op_e op, input word_t a, input word_t b,
                        input signed_mode_t mode, input int exp_lat);
    word_t res;
    int    lat;
    send_op(op, a, b, mode);
    wait_result(res, lat);
    check_value(name, ref_result(op, a, b, mode), res);
    if (exp_lat > 0) begin
      check_value({name, " latency"}, exp_lat, lat);
    end
  endtask

  task automatic mul_random();
    word_t a;
    word_t b;
    for (int i = 0; i < 8; i++) begin
      a = $urandom();
      b = $urandom();
      run_op("MUL", MD_OP_MUL, a, b, (i % 2 == 0) ? 2'b11 : 2'b00, 4);
    end
  endtask

  task automatic mulh_modes();
    signed_mode_t modes [3];
    word_t        corner [2];
    word_t        a;
    word_t        b;
    modes  = '{2'b00, 2'b11, 2'b01};
    corner = '{32'h8000_0000, 32'hFFFF_FFFF};
    for (int m = 0; m < 3; m++) begin
      for (int i = 0; i < 4; i++) begin
        a = $urandom();
        b = $urandom();
        run_op("MULH", MD_OP_MULH, a, b, modes[m], 5);
      end
      for (int i = 0; i < 2; i++) begin
        for (int j = 0; j < 2; j++) begin
          run_op("MULH corner", MD_OP_MULH, corner[i], corner[j], modes[m], 5);
        end
      end
    end
  endtask

  task automatic div_rem_random();
    md_op_e       op;
    signed_mode_t mode;
    string        name;
    word_t        a;
    word_t        b;
    for (int k = 0; k < 4; k++) begin
      op   = k[0] ? MD_OP_REM : MD_OP_DIV;
      mode = k[1] ? 2'b11 : 2'b00;
      name = k[0] ? "REM" : "DIV";
      for (int i = 0; i < 6; i++) begin
        a = $urandom();
        b = (i % 2 == 0) ? word_t'($urandom()) : word_t'($urandom_range(20, 1));
        // Small negative divisor and small negative dividend
        if (i == 3) begin
          b = '0 - b;
        end
        if (i == 4) begin
          a = '0 - word_t'($urandom_range(1000, 1));
        end
        if (b == '0) begin
          b = 32'd7;
        end
        run_op(name, op, a, b, mode, 0);
      end
      // Signed overflow case
      if (k[1]) begin
        run_op({name, " overflow"}, op, 32'h8000_0000, 32'hFFFF_FFFF, mode, 0);
      end
    end
  endtask

  task automatic div_by_zero();
    md_op_e       op;
    signed_mode_t mode;
    for (int k = 0; k < 4; k++) begin
      op   = k[0] ? MD_OP_REM : MD_OP_DIV;
      mode = k[1] ? 2'b11 : 2'b00;
      for (int i = 0; i < 2; i++) begin
        run_op("DIV by zero", op, $urandom(), '0, mode, 3);
      end
    end
  endtask

  task automatic back_pressure();
    word_t first;
    word_t a;
    word_t b;
    word_t next_a;
    word_t next_b;
    int    lat;
    int    hold;
    for (int r = 0; r < 3; r++) begin
      a      = $urandom();
      b      = $urandom();
      next_a = $urandom();
      next_b = $urandom() | 32'd1;
      hold   = $urandom_range(8, 2);
      @(posedge clk_i);
      result_ready_i <= 1'b0;
      send_op(MD_OP_MUL, a, b, 2'b11);
      wait_result(first, lat);
      check_value("back-pressure result", ref_result(MD_OP_MUL, a, b, 2'b11), first);
      check_value("back-pressure latency", 32'd4, lat);
      // Offer the next operation while the result is still held
      @(posedge clk_i);
      start_i       <= 1'b1;
      op_i          <= MD_OP_DIV;
      op_a_i        <= next_a;
      op_b_i        <= next_b;
      signed_mode_i <= 2'b11;
      for (int i = 0; i < hold; i++) begin
        @(negedge clk_i);
        check_value("back-pressure valid", 32'd1, 32'(valid_o));
        check_value("back-pressure hold", first, result_o);
        check_value("back-pressure ready", 32'd0, 32'(ready_o));
      end
      @(posedge clk_i);
      result_ready_i <= 1'b1;
      run_op("back-pressure next", MD_OP_DIV, next_a, next_b, 2'b11, 0);
    end
  endtask

  initial begin
    void'($urandom(39));
    rst_ni         = 1'b0;
    start_i        = 1'b0;
    op_i           = MD_OP_MUL;
    op_a_i         = '0;
    op_b_i         = '0;
    signed_mode_i  = 2'b00;
    result_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("reset ready", 32'd1, 32'(ready_o));
    check_value("reset valid", 32'd0, 32'(valid_o));

    mul_random();
    mulh_modes();
    div_rem_random();
    div_by_zero();
    back_pressure();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- dv/md_sva.sv
// Handshake assertions of the multiply/divide unit
// Bound to the top level

module md_sva
  import md_types_pkg::*;
(
  input logic  clk_i,
  input logic  rst_ni,
  input logic  start_i,
  input logic  ready_o,
  input logic  valid_o,
  input word_t result_o,
  input logic  result_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Result holds until it is retired
  valid_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !result_ready_i) |=> (valid_o && $stable(result_o)))
    else $error("valid_o or result_o changed while result_ready_i was low");

  // A new operation never sees the done of the previous one
  accept_clears_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (start_i && ready_o) |=> !valid_o)
    else $error("valid_o was high in the cycle after an accept");

  valid_after_reset_a : assert property (@(posedge clk_i) $rose(rst_ni) |-> !valid_o)
    else $error("valid_o was high after reset");

endmodule

bind md_top md_sva u_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .start_i        (start_i),
  .ready_o        (ready_o),
  .valid_o        (valid_o),
  .result_o       (result_o),
  .result_ready_i (result_ready_i)
);

//--- design/md_top.sv
// Top level of the sequential multiply/divide unit
// Control block with the multiplier and divider side by side

module md_top
  import md_types_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  input  md_op_e       op_i,
  input  word_t        op_a_i,
  input  word_t        op_b_i,
  input  signed_mode_t signed_mode_i,
  output logic         ready_o,
  output logic         valid_o,
  output word_t        result_o,
  input  logic         result_ready_i
);

  word_t        a, b;
  signed_mode_t mode;
  logic         mult_start, is_high, mult_done, mult_ack;
  logic         div_start, is_rem, div_done, div_ack;
  word_t        mult_result, div_result;

  md_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .op_i           (op_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .signed_mode_i  (signed_mode_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .result_o       (result_o),
    .result_ready_i (result_ready_i),
    .a_o            (a),
    .b_o            (b),
    .mode_o         (mode),
    .mult_start_o   (mult_start),
    .is_high_o      (is_high),
    .div_start_o    (div_start),
    .is_rem_o       (is_rem),
    .mult_done_i    (mult_done),
    .mult_result_i  (mult_result),
    .div_done_i     (div_done),
    .div_result_i   (div_result),
    .mult_ack_o     (mult_ack),
    .div_ack_o      (div_ack)
  );

  md_mult u_mult (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (mult_start),
    .is_high_i (is_high),
    .a_i       (a),
    .b_i       (b),
    .mode_i    (mode),
    .done_o    (mult_done),
    .result_o  (mult_result),
    .ack_i     (mult_ack)
  );

  md_div u_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (div_start),
    .is_rem_i (is_rem),
    .a_i      (a),
    .b_i      (b),
    .mode_i   (mode),
    .done_o   (div_done),
    .result_o (div_result),
    .ack_i    (div_ack)
  );

endmodule

//--- design/md_ctrl.sv
// Control block of the multiply/divide unit
// Captures one operation, starts the matching unit and returns its result

module md_ctrl
  import md_types_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  input  md_op_e       op_i,
  input  word_t        op_a_i,
  input  word_t        op_b_i,
  input  signed_mode_t signed_mode_i,
  output logic         ready_o,
  output logic         valid_o,
  output word_t        result_o,
  input  logic         result_ready_i,
  output word_t        a_o,
  output word_t        b_o,
  output signed_mode_t mode_o,
  output logic         mult_start_o,
  output logic         is_high_o,
  output logic         div_start_o,
  output logic         is_rem_o,
  input  logic         mult_done_i,
  input  word_t        mult_result_i,
  input  logic         div_done_i,
  input  word_t        div_result_i,
  output logic         mult_ack_o,
  output logic         div_ack_o
);

  logic         busy_q;
  logic         issue_q;
  logic         accept;
  logic         is_mult;
  md_op_e       op_q;
  word_t        a_q, b_q;
  signed_mode_t mode_q;

  assign ready_o = ~busy_q;
  assign accept  = start_i & ready_o;
  assign is_mult = (op_q == MD_OP_MUL) || (op_q == MD_OP_MULH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      issue_q <= 1'b0;
      op_q    <= MD_OP_MUL;
    end else begin
      issue_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
        op_q   <= op_i;
      end else if (valid_o && result_ready_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      a_q    <= op_a_i;
      b_q    <= op_b_i;
      mode_q <= signed_mode_i;
    end
  end

  assign a_o    = a_q;
  assign b_o    = b_q;
  assign mode_o = mode_q;

  // One start pulse in the cycle after accept
  assign mult_start_o = issue_q & is_mult;
  assign div_start_o  = issue_q & ~is_mult;
  assign is_high_o    = (op_q == MD_OP_MULH);
  assign is_rem_o     = (op_q == MD_OP_REM);

  assign valid_o  = busy_q & (is_mult ? mult_done_i : div_done_i);
  assign result_o = is_mult ? mult_result_i : div_result_i;

  assign mult_ack_o = is_mult & mult_done_i & result_ready_i;
  assign div_ack_o  = ~is_mult & div_done_i & result_ready_i;

endmodule

//--- div/md_div.sv
// Restoring long divider on operand magnitudes with a final sign fix
// Division by zero exits early with all ones (DIV) or operand a (REM)

`include "md_macros.svh"

module md_div
  import md_types_pkg::*;
  import md_fsm_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  input  logic         is_rem_i,
  input  word_t        a_i,
  input  word_t        b_i,
  input  signed_mode_t mode_i,
  output logic         done_o,
  output word_t        result_o,
  input  logic         ack_i
);

  div_state_e state_q, state_d;
  logic       go_q;
  logic       done_q;
  div_cnt_t   cnt_q;
  div_cnt_t   cnt_nxt;

  // Datapath registers
  word_t      num_q;
  word_t      den_q;
  word_t      quot_q;
  word_t      res_q;
  logic [`MD_XLEN:0] rem_q;

  // Trial subtraction and negation
  logic [`MD_XLEN+1:0] trial;
  logic       ge;
  word_t      next_rem;
  word_t      next_quot;
  word_t      one_shift;
  word_t      neg_op;
  word_t      neg_res;

  logic       sign_a, sign_b;
  logic       b_zero;
  logic       flip;

  assign sign_a = mode_i[0] & a_i[`MD_XLEN-1];
  assign sign_b = mode_i[1] & b_i[`MD_XLEN-1];
  assign b_zero = (b_i == '0);

  // REM takes the sign of a, DIV is negative when the signs differ
  assign flip = is_rem_i ? sign_a : (sign_a ^ sign_b);

  assign cnt_nxt = cnt_q - 1'b1;

  // Partial remainder may reach 33 bits after the shift, so compare on 34
  assign trial     = {1'b0, rem_q} - {2'b00, den_q};
  assign ge        = ~trial[`MD_XLEN+1];
  assign next_rem  = ge ? trial[`MD_XLEN-1:0] : rem_q[`MD_XLEN-1:0];
  assign one_shift = word_t'(1) << cnt_q;
  assign next_quot = ge ? (quot_q | one_shift) : quot_q;

  // One negator serves both absolute values and the sign fix
  always_comb begin
    unique case (state_q)
      DIV_ABS_A: neg_op = a_i;
      DIV_ABS_B: neg_op = b_i;
      default:   neg_op = res_q;
    endcase
  end

  assign neg_res = '0 - neg_op;

  always_comb begin
    state_d = state_q;

    unique case (state_q)
      DIV_IDLE: begin
        if (go_q) begin
          state_d = b_zero ? DIV_FINISH : DIV_ABS_A;
        end
      end
      DIV_ABS_A: state_d = DIV_ABS_B;
      DIV_ABS_B: state_d = DIV_COMP;
      DIV_COMP: begin
        if (cnt_q == div_cnt_t'(1)) begin
          state_d = DIV_LAST;
        end
      end
      DIV_LAST:  state_d = DIV_SIGN;
      DIV_SIGN:  state_d = DIV_FINISH;
      DIV_FINISH: begin
        // Hold the result until it is retired
        if (done_q && ack_i) begin
          state_d = DIV_IDLE;
        end
      end
      default:   state_d = DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      go_q    <= 1'b0;
      done_q  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      go_q    <= start_i;
      if (state_q == DIV_FINISH) begin
        done_q <= ~(done_q & ack_i);
      end
      if (state_q == DIV_IDLE) begin
        cnt_q <= '1;
      end else if (state_q == DIV_COMP) begin
        cnt_q <= cnt_nxt;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    unique case (state_q)
      DIV_IDLE: begin
        if (go_q && b_zero) begin
          res_q <= is_rem_i ? a_i : '1;
        end
      end
      DIV_ABS_A: begin
        num_q  <= sign_a ? neg_res : a_i;
        quot_q <= '0;
      end
      DIV_ABS_B: begin
        den_q <= sign_b ? neg_res : b_i;
        rem_q <= {{`MD_XLEN{1'b0}}, num_q[`MD_XLEN-1]};
      end
      DIV_COMP: begin
        // Bring down the next numerator bit
        rem_q  <= {next_rem, num_q[cnt_nxt]};
        quot_q <= next_quot;
      end
      DIV_LAST: begin
        res_q <= is_rem_i ? next_rem : next_quot;
      end
      DIV_SIGN: begin
        if (flip) begin
          res_q <= neg_res;
        end
      end
      default: begin
      end
    endcase
  end

  assign done_o   = done_q;
  assign result_o = res_q;

endmodule

//--- mult/md_mult.sv
// Sequential multiplier built on one 17x17 signed multiply-accumulate step
// Visits al*bl, al*bh, ah*bl and ah*bh; MUL stops after three steps

`include "md_macros.svh"

module md_mult
  import md_types_pkg::*;
  import md_fsm_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  input  logic         is_high_i,
  input  word_t        a_i,
  input  word_t        b_i,
  input  signed_mode_t mode_i,
  output logic         done_o,
  output word_t        result_o,
  input  logic         ack_i
);

  mult_state_e state_q, state_d;
  logic        run_q;
  logic        done_q;
  logic        last_step;
  acc_t        acc_q, acc_d;

  // MAC operands
  half_t       a_lo, a_hi, b_lo, b_hi;
  half_t       mult_op_a, mult_op_b;
  logic        sign_a, sign_b;
  logic        a_neg, b_neg;
  logic        signed_mult;
  acc_t        accum;
  logic signed [`MD_ACC_W-1:0] mac;

  // Shifted and merged views of the accumulator
  acc_t        acc_lo_shift;
  acc_t        acc_hi_shift;
  acc_t        acc_low_word;

  assign a_lo = a_i[`MD_HALF-1:0];
  assign a_hi = a_i[`MD_XLEN-1:`MD_HALF];
  assign b_lo = b_i[`MD_HALF-1:0];
  assign b_hi = b_i[`MD_XLEN-1:`MD_HALF];

  assign a_neg       = mode_i[0] & a_i[`MD_XLEN-1];
  assign b_neg       = mode_i[1] & b_i[`MD_XLEN-1];
  assign signed_mult = (mode_i != 2'b00);

  // Top bit of the 35-bit sum always equals bit 33, so 34 bits are enough
  assign mac = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b}) + $signed(accum);

  // Carry of the low word into the next half-word position, always unsigned
  assign acc_lo_shift = {{(`MD_ACC_W-`MD_HALF){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
  // High accumulation moved down one half-word for ah*bh
  assign acc_hi_shift = {{`MD_HALF{signed_mult & acc_q[`MD_ACC_W-1]}},
                         acc_q[`MD_ACC_W-1:`MD_HALF]};
  // Low product word, upper half from this step and lower half from al*bl
  assign acc_low_word = {{(`MD_ACC_W-`MD_XLEN){1'b0}}, mac[`MD_HALF-1:0],
                         acc_q[`MD_HALF-1:0]};

  always_comb begin
    mult_op_a = a_lo;
    mult_op_b = b_lo;
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = '0;
    acc_d     = mac;
    state_d   = state_q;
    last_step = 1'b0;

    unique case (state_q)
      ALBL: begin
        state_d = ALBH;
      end

      ALBH: begin
        mult_op_b = b_hi;
        sign_b    = b_neg;
        accum     = acc_lo_shift;
        acc_d     = is_high_i ? mac : acc_low_word;
        state_d   = AHBL;
      end

      AHBL: begin
        mult_op_a = a_hi;
        sign_a    = a_neg;
        if (is_high_i) begin
          accum   = acc_q;
          state_d = AHBH;
        end else begin
          // MUL ends here and holds in AHBL until retired
          accum     = acc_lo_shift;
          acc_d     = acc_low_word;
          last_step = 1'b1;
        end
      end

      AHBH: begin
        mult_op_a = a_hi;
        mult_op_b = b_hi;
        sign_a    = a_neg;
        sign_b    = b_neg;
        accum     = acc_hi_shift;
        last_step = 1'b1;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
      run_q   <= 1'b0;
      done_q  <= 1'b0;
    end else if (done_q && ack_i) begin
      done_q  <= 1'b0;
      state_q <= ALBL;
    end else if (run_q) begin
      state_q <= state_d;
      if (last_step) begin
        run_q  <= 1'b0;
        done_q <= 1'b1;
      end
    end else if (start_i) begin
      run_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (run_q) begin
      acc_q <= acc_d;
    end
  end

  assign done_o   = done_q;
  assign result_o = acc_q[`MD_XLEN-1:0];

endmodule

//--- common/md_fsm_pkg.sv
// State encodings of the multiplier and divider FSMs

package md_fsm_pkg;

  // One state per partial product, ALBL doubles as the idle state
  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN,
    DIV_FINISH
  } div_state_e;

endpackage

//--- common/md_types_pkg.sv
// Data types of the multiply/divide unit
// Operand vectors, accumulator, counter and the operation code

`include "md_macros.svh"

package md_types_pkg;

  // Operand or result word
  typedef logic [`MD_XLEN-1:0] word_t;

  // One half of an operand
  typedef logic [`MD_HALF-1:0] half_t;

  // Multiplier partial sum
  typedef logic [`MD_ACC_W-1:0] acc_t;

  // Quotient bit index during long division
  typedef logic [`MD_CNT_W-1:0] div_cnt_t;

  // Bit 0 marks operand a as signed, bit 1 operand b
  typedef logic [1:0] signed_mode_t;

  typedef enum logic [1:0] {
    MD_OP_MUL  = 2'b00,
    MD_OP_MULH = 2'b01,
    MD_OP_DIV  = 2'b10,
    MD_OP_REM  = 2'b11
  } md_op_e;

endpackage

//--- common/md_macros.svh
// Width and count constants of the multiply/divide unit
// Shared by the type package and the datapath blocks

`ifndef MD_MACROS_SVH
`define MD_MACROS_SVH

// Operand and result width
`define MD_XLEN 32

// Half-word width of one partial product operand
`define MD_HALF 16

// Multiplier accumulator width, two bits above XLEN for carry and sign
`define MD_ACC_W 34

// Bit index of the division step counter
`define MD_CNT_W 5

`endif
